/* flist.f */
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_exec_pkg.sv
logic/inst_decode.sv
logic/operand_mux.sv
logic/alu.sv
logic/reg_state.sv
logic/pc_sp_unit.sv
logic/cpu_top.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

/* run.sh */
#!/bin/bash
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpu_tb -o cpu_sim \
	> build.log 2>&1 \
	&& ./obj_dir/cpu_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "Finished with no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;
	import cpu_isa_pkg::*;

	// what one instruction is expected to do at the memory and trap ports
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
		logic [1:0] en;
		logic [15:0] raddr;
		logic rd;
		logic trap;
	} pred_t;

	logic clk;
	logic reset;
	logic iread_valid;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];
	logic [7:0] model_mem [65536];

	// instruction-level model state
	logic [15:0] m_x;
	logic [15:0] m_y;
	logic [15:0] m_z;
	logic [15:0] m_pc;
	logic [15:0] m_sp;
	logic m_fz;
	logic m_fc;

	integer seed = 32'h917f;
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int cycle_count = 0;
	int cycle_limit = 16;
	logic trap_seen = 1'b0;
	logic [15:0] load_addr;

	cpu_top dut0 (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.iread_valid(iread_valid),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// both memories answer in the same cycle, little-endian
	assign iread_data = {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};
	assign dread_data = {dmem[dread_addr + 16'd1], dmem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite_en[0])
			dmem[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] <= dwrite_data[15:8];
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: the program did not reach its trap after %0d cycles", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
	endfunction

	function automatic logic [7:0] random_byte();
		return 8'($random(seed));
	endfunction

	function automatic logic [15:0] random_word();
		return 16'($random(seed));
	endfunction

	task automatic note_error(input string msg);
		$display("error %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic model_reset();
		m_x = '0;
		m_y = '0;
		m_z = '0;
		m_pc = `CPU_RESET_PC;
		m_sp = `CPU_RESET_SP;
		m_fz = 1'b0;
		m_fc = 1'b0;
	endtask

	// executes one instruction on the model and predicts its port effects
	function automatic pred_t step_model(input logic [23:0] w);
		pred_t p;
		logic [7:0] op;
		logic [7:0] b1;
		logic [7:0] src;
		logic [7:0] xl;
		logic [15:0] imm;
		logic [15:0] d16;
		logic [15:0] nxt;
		logic [8:0] r9;
		logic [16:0] r17;
		logic [1:0] len;
		logic wr;
		logic jumped;
		p = '0;
		op = w[7:0];
		b1 = w[15:8];
		imm = w[23:8];
		d16 = {{8{b1[7]}}, b1};
		xl = m_x[7:0];
		len = 2'd1;
		nxt = m_pc;
		jumped = 1'b0;
		if (op[7:4] >= 4'd1 && op[7:4] <= 4'd3 && op[3:0] <= 4'd8)
		begin
			case (op[7:4])
				4'd1:
				begin
					src = b1;
					len = 2'd2;
				end
				4'd2: src = m_z[7:0];
				default:
				begin
					src = model_mem[imm];
					p.rd = 1'b1;
					p.raddr = imm;
					len = 2'd3;
				end
			endcase
			wr = 1'b1;
			case (op[3:0])
				4'd0: r9 = {1'b0, xl} + {1'b0, src};
				4'd1: r9 = {1'b0, xl} + {1'b0, src} + {8'd0, m_fc};
				4'd2: r9 = {1'b0, xl} - {1'b0, src};
				4'd3:
				begin
					r9 = {1'b0, xl} - {1'b0, src};
					wr = 1'b0;
				end
				4'd4: r9 = {1'b0, xl & src};
				4'd5: r9 = {1'b0, xl | src};
				4'd6: r9 = {1'b0, xl ^ src};
				4'd7: r9 = {1'b0, src} + 9'd1;
				default: r9 = {1'b0, src} - 9'd1;
			endcase
			m_fz = (r9[7:0] == 8'h00);
			// carry only for the arithmetic group
			if (op[3:0] <= 4'd3)
				m_fc = r9[8];
			if (wr)
				m_x[7:0] = r9[7:0];
		end
		else
		begin
			case (op)
				OP_TRAP: p.trap = 1'b1;
				OP_LD_XL_DIR:
				begin
					m_x[7:0] = model_mem[imm];
					p.rd = 1'b1;
					p.raddr = imm;
					len = 2'd3;
				end
				OP_LD_DIR_XL:
				begin
					p.addr = imm;
					p.data = {8'h00, xl};
					p.en = 2'b01;
					model_mem[imm] = xl;
					len = 2'd3;
				end
				OP_PUSH_XL:
				begin
					m_sp = m_sp - 16'd1;
					p.addr = m_sp;
					p.data = {8'h00, xl};
					p.en = 2'b01;
					model_mem[m_sp] = xl;
				end
				OP_POP_XL:
				begin
					p.rd = 1'b1;
					p.raddr = m_sp;
					m_x[7:0] = model_mem[m_sp];
					m_sp = m_sp + 16'd1;
				end
				OP_PUSHW_Y:
				begin
					m_sp = m_sp - 16'd2;
					p.addr = m_sp;
					p.data = m_y;
					p.en = 2'b11;
					model_mem[m_sp] = m_y[7:0];
					model_mem[m_sp + 16'd1] = m_y[15:8];
				end
				OP_POPW_Y:
				begin
					p.rd = 1'b1;
					p.raddr = m_sp;
					m_y = {model_mem[m_sp + 16'd1], model_mem[m_sp]};
					m_sp = m_sp + 16'd2;
				end
				OP_LDW_Y_IMM:
				begin
					m_y = imm;
					len = 2'd3;
				end
				OP_ADDW_Y_X, OP_ADDW_Y_D:
				begin
					r17 = {1'b0, m_y} + {1'b0, (op == OP_ADDW_Y_X) ? m_x : d16};
					m_y = r17[15:0];
					m_fz = (r17[15:0] == 16'h0000);
					m_fc = r17[16];
					len = (op == OP_ADDW_Y_X) ? 2'd1 : 2'd2;
				end
				OP_LDW_X_Y: m_x = m_y;
				OP_LDW_Z_Y: m_z = m_y;
				OP_JP_IMM:
				begin
					nxt = imm;
					jumped = 1'b1;
				end
				OP_JP_Y:
				begin
					nxt = m_y;
					jumped = 1'b1;
				end
				OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
				begin
					len = 2'd2;
					if (op == OP_JR_D || (op == OP_JRZ_D && m_fz) || (op == OP_JRNZ_D && !m_fz)
						|| (op == OP_JRC_D && m_fc) || (op == OP_JRNC_D && !m_fc))
					begin
						nxt = m_pc + d16;
						jumped = 1'b1;
					end
				end
				default: len = 2'd1;
			endcase
		end
		if (!jumped)
			nxt = m_pc + {14'd0, len};
		m_pc = nxt;
		return p;
	endfunction

	// compare at the falling edge, half a cycle after the inputs settle
	always @(negedge clk)
	begin
		pred_t p;
		logic [23:0] w;
		if (reset)
		begin
			if (dwrite_en != 2'b00 || trap)
				note_error("write or trap active during reset");
		end
		else
		begin
			if (iread_addr !== m_pc)
				note_error($sformatf("iread_addr %h expected %h", iread_addr, m_pc));
			if (!iread_valid)
			begin
				if (dwrite_en != 2'b00 || trap)
					note_error("write or trap active while stalled");
			end
			else
			begin
				w = {imem[m_pc + 16'd2], imem[m_pc + 16'd1], imem[m_pc]};
				p = step_model(w);
				if (p.rd && dread_addr !== p.raddr)
					note_error($sformatf("dread_addr %h expected %h", dread_addr, p.raddr));
				if (dwrite_en !== p.en)
					note_error($sformatf("dwrite_en %b expected %b (op %h)", dwrite_en, p.en, w[7:0]));
				else if (p.en != 2'b00 && dwrite_addr !== p.addr)
					note_error($sformatf("dwrite_addr %h expected %h", dwrite_addr, p.addr));
				else if (p.en == 2'b01 && dwrite_data[7:0] !== p.data[7:0])
					note_error($sformatf("byte write %h expected %h", dwrite_data[7:0], p.data[7:0]));
				else if (p.en == 2'b11 && dwrite_data !== p.data)
					note_error($sformatf("word write %h expected %h", dwrite_data, p.data));
				if (trap !== p.trap)
					note_error($sformatf("trap %b expected %b", trap, p.trap));
				if (p.trap)
					trap_seen = 1'b1;
			end
		end
	end

	task automatic emit1(input logic [7:0] op);
		imem[load_addr] = op;
		load_addr = load_addr + 16'd1;
	endtask

	task automatic emit2(input logic [7:0] op, input logic [7:0] b);
		emit1(op);
		emit1(b);
	endtask

	task automatic emit3(input logic [7:0] op, input logic [15:0] v);
		emit1(op);
		emit1(v[7:0]);
		emit1(v[15:8]);
	endtask

	task automatic build_alu8();
		logic [7:0] op;
		for (int i = 0; i <= 8; i++)
		begin
			emit3(OP_LDW_Y_IMM, random_word());
			emit1(OP_LDW_Z_Y);
			for (int form = 1; form <= 3; form++)
			begin
				op = {4'(form), 4'(i)};
				emit3(OP_LD_XL_DIR, {8'h01, random_byte()});
				if (form == 1)
					emit2(op, random_byte());
				else if (form == 2)
					emit1(op);
				else
					emit3(op, {8'h01, random_byte()});
				emit3(OP_LD_DIR_XL, 16'h0200 + 16'(i * 3 + form));
			end
		end
	endtask

	// each conditional jump skips a 3-byte store when taken
	task automatic build_branch();
		int k;
		k = 0;
		for (int i = 0; i < 8; i++)
		begin
			emit2(8'h10 + 8'($unsigned($random(seed)) % 4), random_byte());
			for (int c = 0; c < 4; c++)
			begin
				emit2(OP_JRZ_D + 8'(c), 8'd5);
				emit3(OP_LD_DIR_XL, 16'h0300 + 16'(k));
				k++;
			end
		end
		emit2(OP_JR_D, 8'd5);
		emit3(OP_LD_DIR_XL, 16'h03ff);
		emit3(OP_JP_IMM, load_addr + 16'd3);
	endtask

	task automatic build_wide(input int n);
		for (int i = 0; i < n; i++)
		begin
			emit3(OP_LDW_Y_IMM, random_word());
			emit1(OP_PUSHW_Y);
			emit1(OP_ADDW_Y_X);
			emit1(OP_PUSHW_Y);
			emit2(OP_ADDW_Y_D, random_byte());
			emit1(OP_PUSHW_Y);
			emit3(OP_LD_XL_DIR, {8'h01, random_byte()});
			emit1(OP_PUSH_XL);
			emit2(OP_XOR_IMM, random_byte());
			emit1(OP_PUSH_XL);
			emit1(OP_POP_XL);
			emit3(OP_LD_DIR_XL, 16'h0400 + 16'(2 * i));
			emit1(OP_POP_XL);
			emit3(OP_LD_DIR_XL, 16'h0401 + 16'(2 * i));
			emit1(OP_POPW_Y);
			emit1(OP_LDW_X_Y);
			emit1(OP_POPW_Y);
			emit1(OP_LDW_Z_Y);
			emit1(OP_ADD_ZL);
			emit1(OP_POPW_Y);
			emit1(OP_PUSHW_Y);
		end
	endtask

	task automatic run_test(input string name, input int stall_pct);
		int errors_before;
		int mismatches;
		errors_before = error_count;
		emit1(OP_TRAP);
		cycle_limit = cycle_count + 4 * int'(load_addr - `CPU_RESET_PC) + 8;
		@(posedge clk);
		#1;
		reset = 1'b1;
		iread_valid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		model_reset();
		trap_seen = 1'b0;
		reset = 1'b0;
		while (!trap_seen)
		begin
			iread_valid = ($unsigned($random(seed)) % 100 >= stall_pct);
			@(posedge clk);
			#1;
		end
		iread_valid = 1'b0;
		mismatches = 0;
		for (int a = 0; a < 65536; a++)
			if (dmem[a] !== model_mem[a])
				mismatches++;
		if (mismatches != 0)
			note_error($sformatf("%0d data memory bytes differ from the model", mismatches));
		test_count++;
		if (error_count != errors_before)
			failed_tests++;
		$display("test %s: %s, %0d errors", name,
			(error_count == errors_before) ? "ok" : "failed", error_count - errors_before);
	endtask

	task automatic begin_program();
		load_addr = `CPU_RESET_PC;
	endtask

	initial
	begin
		reset = 1'b1;
		iread_valid = 1'b0;
		for (int a = 0; a < 65536; a++)
		begin
			imem[a] = 8'h00;
			dmem[a] = fill_byte(16'(a));
			model_mem[a] = fill_byte(16'(a));
		end
		model_reset();

		begin_program();
		emit1(OP_NOP);
		emit1(OP_NOP);
		run_test("reset", 0);

		begin_program();
		build_alu8();
		run_test("alu8", 0);

		begin_program();
		build_branch();
		run_test("branch", 0);

		begin_program();
		build_wide(4);
		run_test("wide_stack", 0);

		begin_program();
		build_wide(2);
		build_branch();
		run_test("stall", 35);

		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* dv/cpu_asserts.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_asserts (
	input logic clk,
	input logic reset,
	input logic iread_valid,
	input logic [`CPU_WORD_W-1:0] iread_addr,
	input logic [1:0] dwrite_en
);

	a_reset_no_write: assert property (@(posedge clk) reset |-> dwrite_en == 2'b00)
		else $error("write enable set during reset");

	// a stalled fetch keeps its address into the next cycle
	a_stall_holds_addr: assert property (@(posedge clk)
		(!reset && !iread_valid) |=> (iread_addr == $past(iread_addr)))
		else $error("iread_addr moved during a stall");

	a_stall_no_write: assert property (@(posedge clk) !iread_valid |-> dwrite_en == 2'b00)
		else $error("write while stalled");

endmodule

bind cpu_top cpu_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.iread_valid(iread_valid),
	.iread_addr(iread_addr),
	.dwrite_en(dwrite_en)
);

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
	input logic clk,
	input logic reset,
	output logic [`CPU_WORD_W-1:0] iread_addr,
	input cpu_isa_pkg::inst_word_u iread_data,
	input logic iread_valid,
	output logic [`CPU_WORD_W-1:0] dread_addr,
	input logic [`CPU_WORD_W-1:0] dread_data,
	output logic [`CPU_WORD_W-1:0] dwrite_addr,
	output logic [`CPU_WORD_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import cpu_exec_pkg::*;

	ctrl_t ctrl;
	flags_t flags;
	flags_t alu_flags;
	dmem_wr_t dwr;
	logic accept;
	logic [`CPU_WORD_W-1:0] x;
	logic [`CPU_WORD_W-1:0] y;
	logic [`CPU_WORD_W-1:0] z;
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] sp;
	logic [`CPU_WORD_W-1:0] opa;
	logic [`CPU_WORD_W-1:0] opb;
	logic [`CPU_WORD_W-1:0] result;

	// one instruction per cycle with a genuine fetch
	assign accept = iread_valid && !reset;

	inst_decode u_decode (
		.opcode(iread_data.disp_fmt.opcode),
		.ctrl(ctrl)
	);

	operand_mux u_operands (
		.ctrl(ctrl),
		.inst(iread_data),
		.x(x),
		.y(y),
		.z(z),
		.sp(sp),
		.dread_data(dread_data),
		.result(result),
		.opa(opa),
		.opb(opb),
		.dread_addr(dread_addr),
		.dwr(dwr)
	);

	alu u_alu (
		.op(ctrl.alu_op),
		.opa(opa),
		.opb(opb),
		.c_in(flags.c),
		.result(result),
		.flags_out(alu_flags)
	);

	reg_state u_regs (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.ctrl(ctrl),
		.result(result),
		.flags_in(alu_flags),
		.x(x),
		.y(y),
		.z(z),
		.flags(flags)
	);

	pc_sp_unit u_pc_sp (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.ctrl(ctrl),
		.inst(iread_data),
		.flags(flags),
		.y(y),
		.result(result),
		.pc(pc),
		.sp(sp)
	);

	// fetch address is the pc itself, so it holds during a stall
	assign iread_addr = pc;

	assign dwrite_addr = dwr.addr;
	assign dwrite_data = dwr.data;
	assign dwrite_en = accept ? dwr.be : 2'b00;
	assign trap = accept && ctrl.trap;

endmodule

/* logic/pc_sp_unit.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module pc_sp_unit (
	input logic clk,
	input logic reset,
	input logic accept,
	input cpu_exec_pkg::ctrl_t ctrl,
	input cpu_isa_pkg::inst_word_u inst,
	input cpu_exec_pkg::flags_t flags,
	input logic [`CPU_WORD_W-1:0] y,
	input logic [`CPU_WORD_W-1:0] result,
	output logic [`CPU_WORD_W-1:0] pc,
	output logic [`CPU_WORD_W-1:0] sp
);
	import cpu_exec_pkg::*;

	logic [`CPU_WORD_W-1:0] seq_pc;
	logic [`CPU_WORD_W-1:0] rel_pc;
	logic [`CPU_WORD_W-1:0] next_pc;
	logic [`CPU_WORD_W-1:0] next_sp;
	logic taken;

	assign seq_pc = pc + {{(`CPU_WORD_W-2){1'b0}}, ctrl.len};

	// relative to the jump's own address
	assign rel_pc = pc + {{(`CPU_WORD_W-8){inst.disp_fmt.disp[7]}}, inst.disp_fmt.disp};

	always_comb
	begin
		case (ctrl.br)
			BR_JR: taken = 1'b1;
			BR_JRZ: taken = flags.z;
			BR_JRNZ: taken = !flags.z;
			BR_JRC: taken = flags.c;
			BR_JRNC: taken = !flags.c;
			default: taken = 1'b0;
		endcase
		if (ctrl.br == BR_JP)
			next_pc = result;
		else if (ctrl.br == BR_JPY)
			next_pc = y;
		else if (taken)
			next_pc = rel_pc;
		else
			next_pc = seq_pc;
	end

	always_comb
	begin
		case (ctrl.sp_op)
			SP_DEC1: next_sp = sp - 16'd1;
			SP_INC1: next_sp = sp + 16'd1;
			SP_DEC2: next_sp = sp - 16'd2;
			SP_INC2: next_sp = sp + 16'd2;
			default: next_sp = sp;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `CPU_RESET_PC;
			sp <= `CPU_RESET_SP;
		end
		else if (accept)
		begin
			pc <= next_pc;
			sp <= next_sp;
		end
	end

endmodule

/* logic/reg_state.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_state (
	input logic clk,
	input logic reset,
	input logic accept,
	input cpu_exec_pkg::ctrl_t ctrl,
	input logic [`CPU_WORD_W-1:0] result,
	input cpu_exec_pkg::flags_t flags_in,
	output logic [`CPU_WORD_W-1:0] x,
	output logic [`CPU_WORD_W-1:0] y,
	output logic [`CPU_WORD_W-1:0] z,
	output cpu_exec_pkg::flags_t flags
);
	import cpu_exec_pkg::*;

	logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];
	flags_t mask;

	assign mask = ctrl.flag_mask;

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
			flags <= '0;
		end
		else if (accept)
		begin
			if (ctrl.reg_be[0])
				regs[ctrl.reg_sel][7:0] <= result[7:0];
			if (ctrl.reg_be[1])
				regs[ctrl.reg_sel][15:8] <= result[15:8];
			// only masked flags move
			flags <= flags_t'((flags & ~mask) | (flags_in & mask));
		end
	end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
	input cpu_exec_pkg::alu_op_e op,
	input logic [`CPU_WORD_W-1:0] opa,
	input logic [`CPU_WORD_W-1:0] opb,
	input logic c_in,
	output logic [`CPU_WORD_W-1:0] result,
	output cpu_exec_pkg::flags_t flags_out
);
	import cpu_exec_pkg::*;

	logic [8:0] res8;
	logic [`CPU_WORD_W:0] res16;
	logic wide;

	always_comb
	begin
		res8 = '0;
		res16 = '0;
		wide = 1'b0;
		case (op)
			ALU_ADD: res8 = {1'b0, opa[7:0]} + {1'b0, opb[7:0]};
			ALU_ADC: res8 = {1'b0, opa[7:0]} + {1'b0, opb[7:0]} + {8'd0, c_in};
			// bit 8 ends up as the borrow
			ALU_SUB: res8 = {1'b0, opa[7:0]} - {1'b0, opb[7:0]};
			ALU_AND: res8 = {1'b0, opa[7:0] & opb[7:0]};
			ALU_OR: res8 = {1'b0, opa[7:0] | opb[7:0]};
			ALU_XOR: res8 = {1'b0, opa[7:0] ^ opb[7:0]};
			ALU_INC: res8 = {1'b0, opb[7:0]} + 9'd1;
			ALU_DEC: res8 = {1'b0, opb[7:0]} - 9'd1;
			ALU_ADDW:
			begin
				res16 = {1'b0, opa} + {1'b0, opb};
				wide = 1'b1;
			end
			// pass of opb, full word
			default:
			begin
				res16 = {1'b0, opb};
				wide = 1'b1;
			end
		endcase
	end

	assign result = wide ? res16[`CPU_WORD_W-1:0] : {8'h00, res8[7:0]};

	// flags follow the width of the operation
	assign flags_out.z = wide ? (res16[`CPU_WORD_W-1:0] == '0) : (res8[7:0] == 8'h00);
	assign flags_out.c = wide ? res16[`CPU_WORD_W] : res8[8];
	assign flags_out.n = wide ? res16[`CPU_WORD_W-1] : res8[7];

endmodule

/* logic/operand_mux.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module operand_mux (
	input cpu_exec_pkg::ctrl_t ctrl,
	input cpu_isa_pkg::inst_word_u inst,
	input logic [`CPU_WORD_W-1:0] x,
	input logic [`CPU_WORD_W-1:0] y,
	input logic [`CPU_WORD_W-1:0] z,
	input logic [`CPU_WORD_W-1:0] sp,
	input logic [`CPU_WORD_W-1:0] dread_data,
	input logic [`CPU_WORD_W-1:0] result,
	output logic [`CPU_WORD_W-1:0] opa,
	output logic [`CPU_WORD_W-1:0] opb,
	output logic [`CPU_WORD_W-1:0] dread_addr,
	output cpu_exec_pkg::dmem_wr_t dwr
);
	import cpu_exec_pkg::*;

	logic [`CPU_WORD_W-1:0] imm16;
	logic [`CPU_WORD_W-1:0] disp_sx;

	assign imm16 = inst.imm_fmt.imm;
	assign disp_sx = {{(`CPU_WORD_W-8){inst.disp_fmt.disp[7]}}, inst.disp_fmt.disp};

	assign opa = (ctrl.opa == OPA_Y) ? y : x;

	always_comb
	begin
		case (ctrl.opb)
			OPB_Y: opb = y;
			OPB_ZL: opb = {8'h00, z[7:0]};
			OPB_IMM8: opb = {8'h00, inst.disp_fmt.disp};
			OPB_IMM16: opb = imm16;
			OPB_DISP: opb = disp_sx;
			OPB_MEM: opb = dread_data;
			default: opb = x;
		endcase
	end

	// pop reads at sp before it moves up
	always_comb
	begin
		case (ctrl.mrd)
			MRD_DIR: dread_addr = imm16;
			MRD_SP: dread_addr = sp;
			default: dread_addr = '0;
		endcase
	end

	// stores and pushes write what the alu passed through
	always_comb
	begin
		dwr.data = result;
		case (ctrl.mwr)
			MWR_DIR8:
			begin
				dwr.addr = imm16;
				dwr.be = 2'b01;
			end
			MWR_PUSH8:
			begin
				dwr.addr = sp - 16'd1;
				dwr.be = 2'b01;
			end
			MWR_PUSH16:
			begin
				dwr.addr = sp - 16'd2;
				dwr.be = 2'b11;
			end
			default:
			begin
				dwr.addr = '0;
				dwr.be = 2'b00;
			end
		endcase
	end

endmodule

/* logic/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
	input cpu_isa_pkg::opcode_e opcode,
	output cpu_exec_pkg::ctrl_t ctrl
);
	import cpu_isa_pkg::*;
	import cpu_exec_pkg::*;

	localparam flags_t FL_NONE = '{z: 1'b0, c: 1'b0, n: 1'b0};
	localparam flags_t FL_ZCN = '{z: 1'b1, c: 1'b1, n: 1'b1};
	localparam flags_t FL_ZN = '{z: 1'b1, c: 1'b0, n: 1'b1};

	logic [1:0] mode;

	// 1 imm8, 2 zl, 3 direct byte
	function automatic ctrl_t alu8(alu_op_e op, flags_t mask, logic wr, logic [1:0] m);
		ctrl_t c;
		c = '0;
		c.alu_op = op;
		c.flag_mask = mask;
		c.reg_be = {1'b0, wr};
		c.opb = (m == 2'd1) ? OPB_IMM8 : (m == 2'd2) ? OPB_ZL : OPB_MEM;
		c.mrd = (m == 2'd3) ? MRD_DIR : MRD_NONE;
		c.len = (m == 2'd1) ? 2'd2 : (m == 2'd2) ? 2'd1 : 2'd3;
		return c;
	endfunction

	function automatic ctrl_t load(reg_sel_e sel, logic [1:0] be, opb_sel_e src, inst_len_t len);
		ctrl_t c;
		c = '0;
		c.reg_sel = sel;
		c.reg_be = be;
		c.opb = src;
		c.len = len;
		return c;
	endfunction

	function automatic ctrl_t jump(br_e kind, inst_len_t len);
		ctrl_t c;
		c = '0;
		c.br = kind;
		c.len = len;
		return c;
	endfunction

	assign mode = opcode[5:4];

	always_comb
	begin
		ctrl = '0;
		ctrl.len = 2'd1;
		case (opcode)
			OP_TRAP: ctrl.trap = 1'b1;
			OP_ADD_IMM, OP_ADD_ZL, OP_ADD_DIR: ctrl = alu8(ALU_ADD, FL_ZCN, 1'b1, mode);
			OP_ADC_IMM, OP_ADC_ZL, OP_ADC_DIR: ctrl = alu8(ALU_ADC, FL_ZCN, 1'b1, mode);
			OP_SUB_IMM, OP_SUB_ZL, OP_SUB_DIR: ctrl = alu8(ALU_SUB, FL_ZCN, 1'b1, mode);
			// compare keeps xl
			OP_CP_IMM, OP_CP_ZL, OP_CP_DIR: ctrl = alu8(ALU_SUB, FL_ZCN, 1'b0, mode);
			OP_AND_IMM, OP_AND_ZL, OP_AND_DIR: ctrl = alu8(ALU_AND, FL_ZN, 1'b1, mode);
			OP_OR_IMM, OP_OR_ZL, OP_OR_DIR: ctrl = alu8(ALU_OR, FL_ZN, 1'b1, mode);
			OP_XOR_IMM, OP_XOR_ZL, OP_XOR_DIR: ctrl = alu8(ALU_XOR, FL_ZN, 1'b1, mode);
			OP_INC_IMM, OP_INC_ZL, OP_INC_DIR: ctrl = alu8(ALU_INC, FL_ZN, 1'b1, mode);
			OP_DEC_IMM, OP_DEC_ZL, OP_DEC_DIR: ctrl = alu8(ALU_DEC, FL_ZN, 1'b1, mode);
			OP_LD_XL_DIR: ctrl = alu8(ALU_PASS, FL_NONE, 1'b1, 2'd3);
			OP_LD_DIR_XL:
			begin
				ctrl.mwr = MWR_DIR8;
				ctrl.len = 2'd3;
			end
			OP_PUSH_XL:
			begin
				ctrl.mwr = MWR_PUSH8;
				ctrl.sp_op = SP_DEC1;
			end
			OP_POP_XL:
			begin
				ctrl = load(REG_X, 2'b01, OPB_MEM, 2'd1);
				ctrl.mrd = MRD_SP;
				ctrl.sp_op = SP_INC1;
			end
			OP_PUSHW_Y:
			begin
				ctrl.opb = OPB_Y;
				ctrl.mwr = MWR_PUSH16;
				ctrl.sp_op = SP_DEC2;
			end
			OP_POPW_Y:
			begin
				ctrl = load(REG_Y, 2'b11, OPB_MEM, 2'd1);
				ctrl.mrd = MRD_SP;
				ctrl.sp_op = SP_INC2;
			end
			OP_LDW_Y_IMM: ctrl = load(REG_Y, 2'b11, OPB_IMM16, 2'd3);
			OP_LDW_X_Y: ctrl = load(REG_X, 2'b11, OPB_Y, 2'd1);
			OP_LDW_Z_Y: ctrl = load(REG_Z, 2'b11, OPB_Y, 2'd1);
			OP_ADDW_Y_X:
			begin
				ctrl = load(REG_Y, 2'b11, OPB_X, 2'd1);
				ctrl.alu_op = ALU_ADDW;
				ctrl.opa = OPA_Y;
				ctrl.flag_mask = FL_ZCN;
			end
			OP_ADDW_Y_D:
			begin
				ctrl = load(REG_Y, 2'b11, OPB_DISP, 2'd2);
				ctrl.alu_op = ALU_ADDW;
				ctrl.opa = OPA_Y;
				ctrl.flag_mask = FL_ZCN;
			end
			// target goes through the alu as a pass
			OP_JP_IMM:
			begin
				ctrl = jump(BR_JP, 2'd3);
				ctrl.opb = OPB_IMM16;
			end
			OP_JP_Y: ctrl = jump(BR_JPY, 2'd1);
			OP_JR_D: ctrl = jump(BR_JR, 2'd2);
			OP_JRZ_D: ctrl = jump(BR_JRZ, 2'd2);
			OP_JRNZ_D: ctrl = jump(BR_JRNZ, 2'd2);
			OP_JRC_D: ctrl = jump(BR_JRC, 2'd2);
			OP_JRNC_D: ctrl = jump(BR_JRNC, 2'd2);
			// nop, and anything unknown runs as a one-byte nop
			default: ctrl.len = 2'd1;
		endcase
	end

endmodule

/* logic/cpu_exec_pkg.sv */
`include "cpu_params.svh"

package cpu_exec_pkg;

	// pass first, so an all-zero control word is a nop
	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_INC, ALU_DEC, ALU_ADDW
	} alu_op_e;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flags_t;

	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_e;

	typedef enum logic {OPA_X, OPA_Y} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_X, OPB_Y, OPB_ZL, OPB_IMM8, OPB_IMM16, OPB_DISP, OPB_MEM
	} opb_sel_e;

	typedef enum logic [1:0] {MRD_NONE, MRD_DIR, MRD_SP} mrd_e;

	typedef enum logic [1:0] {MWR_NONE, MWR_DIR8, MWR_PUSH8, MWR_PUSH16} mwr_e;

	typedef enum logic [2:0] {SP_HOLD, SP_DEC1, SP_INC1, SP_DEC2, SP_INC2} sp_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_JP, BR_JPY, BR_JR, BR_JRZ, BR_JRNZ, BR_JRC, BR_JRNC
	} br_e;

	typedef struct packed {
		alu_op_e alu_op;
		opa_sel_e opa;
		opb_sel_e opb;
		reg_sel_e reg_sel;
		logic [1:0] reg_be;
		flags_t flag_mask;
		mrd_e mrd;
		mwr_e mwr;
		sp_op_e sp_op;
		br_e br;
		cpu_isa_pkg::inst_len_t len;
		logic trap;
	} ctrl_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;
		logic [`CPU_WORD_W-1:0] data;
		logic [1:0] be;
	} dmem_wr_t;

endpackage

/* logic/cpu_isa_pkg.sv */
`include "cpu_params.svh"

package cpu_isa_pkg;

	// 8-bit alu forms: 0x1n imm8, 0x2n zl, 0x3n direct byte
	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_ADD_IMM = 8'h10, OP_ADD_ZL = 8'h20, OP_ADD_DIR = 8'h30,
		OP_ADC_IMM = 8'h11, OP_ADC_ZL = 8'h21, OP_ADC_DIR = 8'h31,
		OP_SUB_IMM = 8'h12, OP_SUB_ZL = 8'h22, OP_SUB_DIR = 8'h32,
		OP_CP_IMM = 8'h13, OP_CP_ZL = 8'h23, OP_CP_DIR = 8'h33,
		OP_AND_IMM = 8'h14, OP_AND_ZL = 8'h24, OP_AND_DIR = 8'h34,
		OP_OR_IMM = 8'h15, OP_OR_ZL = 8'h25, OP_OR_DIR = 8'h35,
		OP_XOR_IMM = 8'h16, OP_XOR_ZL = 8'h26, OP_XOR_DIR = 8'h36,
		OP_INC_IMM = 8'h17, OP_INC_ZL = 8'h27, OP_INC_DIR = 8'h37,
		OP_DEC_IMM = 8'h18, OP_DEC_ZL = 8'h28, OP_DEC_DIR = 8'h38,
		OP_LD_XL_DIR = 8'h40,
		OP_LD_DIR_XL = 8'h41,
		OP_PUSH_XL = 8'h50,
		OP_POP_XL = 8'h51,
		OP_PUSHW_Y = 8'h52,
		OP_POPW_Y = 8'h53,
		OP_LDW_Y_IMM = 8'h60,
		OP_ADDW_Y_X = 8'h61,
		OP_ADDW_Y_D = 8'h62,
		OP_LDW_X_Y = 8'h63,
		OP_LDW_Z_Y = 8'h64,
		OP_JP_IMM = 8'h70,
		OP_JP_Y = 8'h71,
		OP_JR_D = 8'h72,
		OP_JRZ_D = 8'h73,
		OP_JRNZ_D = 8'h74,
		OP_JRC_D = 8'h75,
		OP_JRNC_D = 8'h76
	} opcode_e;

	// bytes consumed, 1 to 3
	typedef logic [1:0] inst_len_t;

	// opcode in the low byte, fetched little-endian
	typedef struct packed {
		logic [`CPU_INST_W-17:0] spare;
		logic [7:0] disp;
		opcode_e opcode;
	} inst_disp_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] imm;
		opcode_e opcode;
	} inst_imm_t;

	typedef union packed {
		inst_disp_t disp_fmt;
		inst_imm_t imm_fmt;
	} inst_word_u;

endpackage

/* logic/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and address width
`define CPU_WORD_W 16

// fetch window: opcode plus up to two operand bytes
`define CPU_INST_W 24

// x, y and z
`define CPU_NUM_REGS 3

// first fetch after reset
`define CPU_RESET_PC 16'h4000

// stack grows down from here
`define CPU_RESET_SP 16'h8000

`endif
